// ==== design/agent_ingress.sv ====
// Per-agent request queues and the least-pending arbiter.
// Each cycle the nonempty queue with the fewest entries offers its head on arb_if;
// ties go to the lowest agent index.

`timescale 1ns/100ps
`default_nettype none

module agent_ingress
  import mem_arb_pkg::*;
(
  input  logic                  cntrlr_clk,
  input  logic                  cntrlr_rst_n,
  input  logic [NUM_AGENTS-1:0] agent_wren,
  input  logic [NUM_AGENTS-1:0] agent_rden,
  input  logic [MEM_ADDR_W-1:0] agent_addr  [NUM_AGENTS],
  input  logic [MEM_DATA_W-1:0] agent_wdata [NUM_AGENTS],
  output logic [NUM_AGENTS-1:0] agent_wait,
  arb_xtn_if.src                arb_if
);

  // Queue storage, one circular buffer per agent
  logic                  wren_mem  [NUM_AGENTS][INGR_DEPTH];
  logic                  rden_mem  [NUM_AGENTS][INGR_DEPTH];
  logic [MEM_ADDR_W-1:0] addr_mem  [NUM_AGENTS][INGR_DEPTH];
  logic [MEM_DATA_W-1:0] wdata_mem [NUM_AGENTS][INGR_DEPTH];

  logic [INGR_PTR_W-1:0] wr_ptr [NUM_AGENTS];
  logic [INGR_PTR_W-1:0] rd_ptr [NUM_AGENTS];
  logic [INGR_CNT_W-1:0] cnt    [NUM_AGENTS];

  logic [NUM_AGENTS-1:0] push;
  logic [NUM_AGENTS-1:0] pop;

  logic [AGENT_ID_W-1:0] sel_id;
  logic [INGR_CNT_W-1:0] sel_cnt;
  logic                  any_pend;

  genvar g;

  // Least-pending pick over the registered counts
  always_comb
  begin
    sel_id   = '0;
    sel_cnt  = '1;
    any_pend = 1'b0;
    for (int i = 0; i < NUM_AGENTS; i++)
    begin
      // Strict compare keeps the lower index on a tie
      if ((cnt[i] != '0) && (cnt[i] < sel_cnt))
      begin
        sel_id   = AGENT_ID_W'(i);
        sel_cnt  = cnt[i];
        any_pend = 1'b1;
      end
    end
  end

  always_comb
  begin
    for (int i = 0; i < NUM_AGENTS; i++)
    begin
      agent_wait[i] = (cnt[i] == INGR_CNT_W'(INGR_DEPTH));
      // Strobes seen while the queue is full are dropped
      push[i]       = (agent_wren[i] | agent_rden[i]) & ~agent_wait[i];
      pop[i]        = arb_if.vld & arb_if.take & (sel_id == AGENT_ID_W'(i));
    end
  end

  // Head of the selected queue
  assign arb_if.vld      = any_pend;
  assign arb_if.wren     = wren_mem[sel_id][rd_ptr[sel_id]];
  assign arb_if.rden     = rden_mem[sel_id][rd_ptr[sel_id]];
  assign arb_if.addr     = addr_mem[sel_id][rd_ptr[sel_id]];
  assign arb_if.wdata    = wdata_mem[sel_id][rd_ptr[sel_id]];
  assign arb_if.agent_id = sel_id;

  always_ff @(posedge cntrlr_clk)
  begin
    for (int i = 0; i < NUM_AGENTS; i++)
    begin
      if (push[i])
      begin
        wren_mem[i][wr_ptr[i]]  <= agent_wren[i];
        rden_mem[i][wr_ptr[i]]  <= agent_rden[i];
        addr_mem[i][wr_ptr[i]]  <= agent_addr[i];
        wdata_mem[i][wr_ptr[i]] <= agent_wdata[i];
      end
    end
  end

  always_ff @(posedge cntrlr_clk or negedge cntrlr_rst_n)
  begin
    if (!cntrlr_rst_n)
    begin
      for (int i = 0; i < NUM_AGENTS; i++)
      begin
        wr_ptr[i] <= '0;
        rd_ptr[i] <= '0;
        cnt[i]    <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < NUM_AGENTS; i++)
      begin
        if (push[i])
        begin
          wr_ptr[i] <= wr_ptr[i] + 1'b1;
        end
        if (pop[i])
        begin
          rd_ptr[i] <= rd_ptr[i] + 1'b1;
        end
        // Push and pop together leave the count unchanged
        case ({push[i], pop[i]})
          2'b10:   cnt[i] <= cnt[i] + 1'b1;
          2'b01:   cnt[i] <= cnt[i] - 1'b1;
          default: cnt[i] <= cnt[i];
        endcase
      end
    end
  end

  // Count stays within the depth when no push reaches a full queue
  for (g = 0; g < NUM_AGENTS; g++)
  begin : gen_chk
    a_no_push_full: assert property (
      @(posedge cntrlr_clk) disable iff (!cntrlr_rst_n)
      cnt[g] <= INGR_CNT_W'(INGR_DEPTH));
  end

endmodule

`default_nettype wire

// ==== design/arb_xtn_if.sv ====
// One memory request moving between two arbiter stages.
// A request transfers on a rising edge where vld and take are both high.

`timescale 1ns/100ps
`default_nettype none

interface arb_xtn_if
  import mem_arb_pkg::*;
();

  logic                  vld;
  logic                  take;
  logic                  wren;
  logic                  rden;
  logic [MEM_ADDR_W-1:0] addr;
  logic [MEM_DATA_W-1:0] wdata;
  logic [AGENT_ID_W-1:0] agent_id;

  // Producer side
  modport src (output vld, wren, rden, addr, wdata, agent_id, input take);

  // Consumer side
  modport snk (input vld, wren, rden, addr, wdata, agent_id, output take);

endinterface

`default_nettype wire

// ==== design/cntrlr_issue.sv ====
// Presents the head request to the memory controller and routes read data back.
// Agent IDs of accepted reads are queued in issue order; each returned word
// goes to the agent at the head of that queue.

`timescale 1ns/100ps
`default_nettype none

module cntrlr_issue
  import mem_arb_pkg::*;
(
  input  logic                  cntrlr_clk,
  input  logic                  cntrlr_rst_n,
  arb_xtn_if.snk                iss_if,
  input  logic                  cntrlr_rdy,
  output logic                  cntrlr_wren,
  output logic                  cntrlr_rden,
  output logic [MEM_ADDR_W-1:0] cntrlr_addr,
  output logic [MEM_DATA_W-1:0] cntrlr_wdata,
  input  logic                  cntrlr_rd_valid,
  input  logic [MEM_DATA_W-1:0] cntrlr_rdata,
  output logic [NUM_AGENTS-1:0] agent_rd_valid,
  output logic [MEM_DATA_W-1:0] agent_rdata
);

  logic [AGENT_ID_W-1:0] rid_mem [RID_DEPTH];
  logic [RID_PTR_W-1:0]  rid_wr_ptr;
  logic [RID_PTR_W-1:0]  rid_rd_ptr;
  logic [RID_CNT_W-1:0]  rid_cnt;
  logic                  rid_full;
  logic                  rid_empty;
  logic                  rid_push;
  logic                  rid_pop;
  logic [AGENT_ID_W-1:0] rid_head;
  logic                  rd_hold;

  assign rid_full  = (rid_cnt == RID_CNT_W'(RID_DEPTH));
  assign rid_empty = (rid_cnt == '0);

  // A read at the head waits while there is no room to record its ID
  assign rd_hold = iss_if.rden & rid_full;

  assign cntrlr_wren  = iss_if.vld & iss_if.wren & ~rd_hold;
  assign cntrlr_rden  = iss_if.vld & iss_if.rden & ~rd_hold;
  assign cntrlr_addr  = iss_if.addr;
  assign cntrlr_wdata = iss_if.wdata;
  assign iss_if.take  = cntrlr_rdy & ~rd_hold;

  assign rid_push = cntrlr_rden & cntrlr_rdy;
  assign rid_pop  = cntrlr_rd_valid;
  assign rid_head = rid_mem[rid_rd_ptr];

  always_ff @(posedge cntrlr_clk)
  begin
    if (rid_push)
    begin
      rid_mem[rid_wr_ptr] <= iss_if.agent_id;
    end
  end

  always_ff @(posedge cntrlr_clk or negedge cntrlr_rst_n)
  begin
    if (!cntrlr_rst_n)
    begin
      rid_wr_ptr <= '0;
      rid_rd_ptr <= '0;
      rid_cnt    <= '0;
    end
    else
    begin
      if (rid_push)
      begin
        rid_wr_ptr <= rid_wr_ptr + 1'b1;
      end
      if (rid_pop)
      begin
        rid_rd_ptr <= rid_rd_ptr + 1'b1;
      end
      rid_cnt <= rid_cnt + RID_CNT_W'(rid_push) - RID_CNT_W'(rid_pop);
    end
  end

  // Decode the oldest outstanding ID into a one-hot valid
  always_comb
  begin
    for (int i = 0; i < NUM_AGENTS; i++)
    begin
      agent_rd_valid[i] = cntrlr_rd_valid & (rid_head == AGENT_ID_W'(i));
    end
  end

  // Data is shared by all agents, qualified by agent_rd_valid
  assign agent_rdata = cntrlr_rdata;

  // Controller must only return data for reads it has accepted
  a_no_orphan_rdata: assert property (
    @(posedge cntrlr_clk) disable iff (!cntrlr_rst_n)
    cntrlr_rd_valid |-> !rid_empty);

endmodule

`default_nettype wire

// ==== design/issue_queue.sv ====
// First-word-fall-through queue between the arbiter and the controller side.
// Takes from arb_if while not full and offers its head on iss_if while not empty.

`timescale 1ns/100ps
`default_nettype none

module issue_queue
  import mem_arb_pkg::*;
(
  input  logic    cntrlr_clk,
  input  logic    cntrlr_rst_n,
  arb_xtn_if.snk  arb_if,
  arb_xtn_if.src  iss_if
);

  logic                   wren_mem  [ISSUE_DEPTH];
  logic                   rden_mem  [ISSUE_DEPTH];
  logic [MEM_ADDR_W-1:0]  addr_mem  [ISSUE_DEPTH];
  logic [MEM_DATA_W-1:0]  wdata_mem [ISSUE_DEPTH];
  logic [AGENT_ID_W-1:0]  id_mem    [ISSUE_DEPTH];

  logic [ISSUE_PTR_W-1:0] wr_ptr;
  logic [ISSUE_PTR_W-1:0] rd_ptr;
  logic [ISSUE_CNT_W-1:0] count;
  logic                   full;
  logic                   empty;
  logic                   wr;
  logic                   rd;

  assign full        = (count == ISSUE_CNT_W'(ISSUE_DEPTH));
  assign empty       = (count == '0);
  assign arb_if.take = ~full;
  assign iss_if.vld  = ~empty;
  assign wr          = arb_if.vld & arb_if.take;
  assign rd          = iss_if.vld & iss_if.take;

  always_ff @(posedge cntrlr_clk)
  begin
    if (wr)
    begin
      wren_mem[wr_ptr]  <= arb_if.wren;
      rden_mem[wr_ptr]  <= arb_if.rden;
      addr_mem[wr_ptr]  <= arb_if.addr;
      wdata_mem[wr_ptr] <= arb_if.wdata;
      id_mem[wr_ptr]    <= arb_if.agent_id;
    end
  end

  // Head entry is visible as soon as it is written
  assign iss_if.wren     = wren_mem[rd_ptr];
  assign iss_if.rden     = rden_mem[rd_ptr];
  assign iss_if.addr     = addr_mem[rd_ptr];
  assign iss_if.wdata    = wdata_mem[rd_ptr];
  assign iss_if.agent_id = id_mem[rd_ptr];

  always_ff @(posedge cntrlr_clk or negedge cntrlr_rst_n)
  begin
    if (!cntrlr_rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + ISSUE_CNT_W'(wr) - ISSUE_CNT_W'(rd);
    end
  end

  // Count stays within the depth when no write reaches a full queue
  a_no_wr_full: assert property (
    @(posedge cntrlr_clk) disable iff (!cntrlr_rst_n)
    count <= ISSUE_CNT_W'(ISSUE_DEPTH));

  // A read from an empty queue would wrap the count
  a_no_rd_empty: assert property (
    @(posedge cntrlr_clk) disable iff (!cntrlr_rst_n)
    empty |=> (count <= ISSUE_CNT_W'(1)));

endmodule

`default_nettype wire

// ==== design/mem_arb_pkg.sv ====
// Widths, counts and queue depths shared by the least-pending memory arbiter.
// Each design module imports it in its header, and the testbench imports it too.

`default_nettype none

package mem_arb_pkg;

  // Requesting agents and the width of an agent index
  localparam int NUM_AGENTS  = 4;
  localparam int AGENT_ID_W  = 2;

  // Memory word and address widths
  localparam int MEM_ADDR_W  = 16;
  localparam int MEM_DATA_W  = 32;

  // Per-agent ingress queue
  localparam int INGR_DEPTH  = 8;
  localparam int INGR_CNT_W  = 4;
  localparam int INGR_PTR_W  = $clog2(INGR_DEPTH);

  // Arbitrated requests waiting for the controller
  localparam int ISSUE_DEPTH = 4;
  localparam int ISSUE_PTR_W = $clog2(ISSUE_DEPTH);
  localparam int ISSUE_CNT_W = $clog2(ISSUE_DEPTH) + 1;

  // Agent IDs of reads still waiting for data
  localparam int RID_DEPTH   = 16;
  localparam int RID_PTR_W   = $clog2(RID_DEPTH);
  localparam int RID_CNT_W   = $clog2(RID_DEPTH) + 1;

endpackage

`default_nettype wire

// ==== design/mem_arb_top.sv ====
// Top level of the least-pending memory arbiter.
// Agents on one side, the memory controller on the other, all on cntrlr_clk.

`timescale 1ns/100ps
`default_nettype none

module mem_arb_top
  import mem_arb_pkg::*;
(
  input  logic                  cntrlr_clk,
  input  logic                  cntrlr_rst_n,

  // Agent side
  input  logic [NUM_AGENTS-1:0] agent_wren,
  input  logic [NUM_AGENTS-1:0] agent_rden,
  input  logic [MEM_ADDR_W-1:0] agent_addr  [NUM_AGENTS],
  input  logic [MEM_DATA_W-1:0] agent_wdata [NUM_AGENTS],
  output logic [NUM_AGENTS-1:0] agent_wait,
  output logic [NUM_AGENTS-1:0] agent_rd_valid,
  output logic [MEM_DATA_W-1:0] agent_rdata,

  // Controller side
  input  logic                  cntrlr_rdy,
  output logic                  cntrlr_wren,
  output logic                  cntrlr_rden,
  output logic [MEM_ADDR_W-1:0] cntrlr_addr,
  output logic [MEM_DATA_W-1:0] cntrlr_wdata,
  input  logic                  cntrlr_rd_valid,
  input  logic [MEM_DATA_W-1:0] cntrlr_rdata
);

  // Arbiter to issue queue, then issue queue to controller
  arb_xtn_if arb_if ();
  arb_xtn_if iss_if ();

  agent_ingress u_agent_ingress (
    .cntrlr_clk   (cntrlr_clk),
    .cntrlr_rst_n (cntrlr_rst_n),
    .agent_wren   (agent_wren),
    .agent_rden   (agent_rden),
    .agent_addr   (agent_addr),
    .agent_wdata  (agent_wdata),
    .agent_wait   (agent_wait),
    .arb_if       (arb_if)
  );

  issue_queue u_issue_queue (
    .cntrlr_clk   (cntrlr_clk),
    .cntrlr_rst_n (cntrlr_rst_n),
    .arb_if       (arb_if),
    .iss_if       (iss_if)
  );

  cntrlr_issue u_cntrlr_issue (
    .cntrlr_clk      (cntrlr_clk),
    .cntrlr_rst_n    (cntrlr_rst_n),
    .iss_if          (iss_if),
    .cntrlr_rdy      (cntrlr_rdy),
    .cntrlr_wren     (cntrlr_wren),
    .cntrlr_rden     (cntrlr_rden),
    .cntrlr_addr     (cntrlr_addr),
    .cntrlr_wdata    (cntrlr_wdata),
    .cntrlr_rd_valid (cntrlr_rd_valid),
    .cntrlr_rdata    (cntrlr_rdata),
    .agent_rd_valid  (agent_rd_valid),
    .agent_rdata     (agent_rdata)
  );

endmodule

`default_nettype wire

// ==== list.f ====
design/mem_arb_pkg.sv
design/arb_xtn_if.sv
design/agent_ingress.sv
design/issue_queue.sv
design/cntrlr_issue.sv
design/mem_arb_top.sv
tb/tb_mem_arb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and decide pass or fail from the log
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module tb_mem_arb \
  && ./obj_dir/Vtb_mem_arb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Done: no errors" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== tb/tb_mem_arb.sv ====
// Random-stimulus testbench for the least-pending memory arbiter.
// A cycle model of the ingress queues, issue queue and read-ID queue predicts
// every DUT output, and the outputs are checked at the falling clock edge.

`timescale 1ns/100ps
`default_nettype none

module tb_mem_arb
  import mem_arb_pkg::*;
();

  localparam int NUM_REQ = 600;
  localparam int RD_BIT  = MEM_ADDR_W + MEM_DATA_W;
  localparam int WR_BIT  = RD_BIT + 1;
  localparam int REQ_W   = RD_BIT + 2;

  logic                  cntrlr_clk      = 1'b0;
  logic                  cntrlr_rst_n    = 1'b0;
  logic [NUM_AGENTS-1:0] agent_wren      = '0;
  logic [NUM_AGENTS-1:0] agent_rden      = '0;
  logic [MEM_ADDR_W-1:0] agent_addr  [NUM_AGENTS] = '{default: '0};
  logic [MEM_DATA_W-1:0] agent_wdata [NUM_AGENTS] = '{default: '0};
  logic [NUM_AGENTS-1:0] agent_wait;
  logic [NUM_AGENTS-1:0] agent_rd_valid;
  logic [MEM_DATA_W-1:0] agent_rdata;
  logic                  cntrlr_rdy      = 1'b0;
  logic                  cntrlr_wren;
  logic                  cntrlr_rden;
  logic [MEM_ADDR_W-1:0] cntrlr_addr;
  logic [MEM_DATA_W-1:0] cntrlr_wdata;
  logic                  cntrlr_rd_valid = 1'b0;
  logic [MEM_DATA_W-1:0] cntrlr_rdata    = '0;

  // Ingress model entries are {wren, rden, addr, wdata}
  integer                           seed = 32'h3727;
  logic [REQ_W-1:0]                 ingr_q [NUM_AGENTS][$];
  logic [AGENT_ID_W+REQ_W-1:0]      iss_q [$];
  logic [AGENT_ID_W+MEM_DATA_W-1:0] rd_pend [$];
  logic [MEM_DATA_W-1:0]            mem_model [logic [MEM_ADDR_W-1:0]];
  int                               sent = 0;
  int                               issued = 0;
  int                               sent_per   [NUM_AGENTS] = '{default: 0};
  int                               issued_per [NUM_AGENTS] = '{default: 0};
  int                               low_left = 150;
  logic [NUM_AGENTS-1:0]            saw_full = '0;
  logic                             run_en = 1'b0;

  mem_arb_top UUT (.*);

  always #50 cntrlr_clk = ~cntrlr_clk;

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "Stopped at the first failing check");
  endtask

  // Contents of a location never written
  function automatic logic [MEM_DATA_W-1:0] fill_word(input logic [MEM_ADDR_W-1:0] a);
    return {a ^ 16'h5a5a, ~a};
  endfunction

  always @(posedge cntrlr_clk)
  begin : drive_inputs
    int r;
    if (run_en)
    begin
      for (int i = 0; i < NUM_AGENTS; i++)
      begin
        r = $random(seed);
        // Strobe only while the agent's queue has room
        if ((sent < NUM_REQ) && (ingr_q[i].size() < INGR_DEPTH) && ((r & 7) == 0))
        begin
          agent_wren[i]  <= r[4];
          agent_rden[i]  <= ~r[4];
          agent_addr[i]  <= MEM_ADDR_W'($random(seed)) & 16'h00ff;
          agent_wdata[i] <= $random(seed);
          sent++;
          sent_per[i]++;
        end
        else
        begin
          agent_wren[i] <= 1'b0;
          agent_rden[i] <= 1'b0;
        end
      end
      r = $random(seed);
      if (low_left != 0)
      begin
        cntrlr_rdy <= 1'b0;
        low_left--;
      end
      else
      begin
        // Rare long stall, otherwise ready three cycles in four
        if (((r >> 4) & 255) == 0)
        begin
          low_left = 100 + ((r >> 12) & 63);
        end
        cntrlr_rdy <= ((r & 3) != 0);
      end
      r = $random(seed);
      // Memory answers the oldest read after a random delay
      if ((rd_pend.size() != 0) && ((r & 7) < 3))
      begin
        cntrlr_rd_valid <= 1'b1;
        cntrlr_rdata    <= rd_pend[0][MEM_DATA_W-1:0];
      end
      else
      begin
        cntrlr_rd_valid <= 1'b0;
        cntrlr_rdata    <= '0;
      end
    end
  end

  always @(negedge cntrlr_clk)
  begin : model_step
    logic [NUM_AGENTS-1:0]       exp_wait;
    logic [NUM_AGENTS-1:0]       exp_rv;
    logic [AGENT_ID_W+REQ_W-1:0] head;
    logic [REQ_W-1:0]            req;
    logic [MEM_ADDR_W-1:0]       a;
    logic [MEM_DATA_W-1:0]       rdw;
    logic                        exp_wr;
    logic                        exp_rd;
    logic                        arb_take;
    int                          sel;
    int                          sel_cnt;
    if (run_en)
    begin
      // Least-pending pick over the counts left by the previous edge
      sel     = -1;
      sel_cnt = INGR_DEPTH + 1;
      for (int i = 0; i < NUM_AGENTS; i++)
      begin
        exp_wait[i] = (ingr_q[i].size() == INGR_DEPTH);
        saw_full[i] = saw_full[i] | exp_wait[i];
        if ((ingr_q[i].size() != 0) && (ingr_q[i].size() < sel_cnt))
        begin
          sel     = i;
          sel_cnt = ingr_q[i].size();
        end
      end
      assert (agent_wait == exp_wait)
        else report_fail($sformatf("Error backpressure: expected %b, actual %b",
                                   exp_wait, agent_wait));
      arb_take = (iss_q.size() < ISSUE_DEPTH);

      exp_wr = 1'b0;
      exp_rd = 1'b0;
      head   = '0;
      if (iss_q.size() != 0)
      begin
        head = iss_q[0];
        // A read waits while the read-ID queue is full
        if (!(head[RD_BIT] && (rd_pend.size() == RID_DEPTH)))
        begin
          exp_wr = head[WR_BIT];
          exp_rd = head[RD_BIT];
        end
      end
      a = head[MEM_DATA_W +: MEM_ADDR_W];
      assert ({cntrlr_wren, cntrlr_rden} == {exp_wr, exp_rd})
        else report_fail($sformatf("Error ctrl_order: expected strobes %b, actual %b",
                                   {exp_wr, exp_rd}, {cntrlr_wren, cntrlr_rden}));
      if (exp_wr || exp_rd)
      begin
        assert (cntrlr_addr == a)
          else report_fail($sformatf("Error ctrl_order: expected addr %h, actual %h",
                                     a, cntrlr_addr));
      end
      if (exp_wr)
      begin
        assert (cntrlr_wdata == head[MEM_DATA_W-1:0])
          else report_fail($sformatf("Error ctrl_order: expected wdata %h, actual %h",
                                     head[MEM_DATA_W-1:0], cntrlr_wdata));
      end

      // Requests the DUT hands over, credited to the agent at the model's head
      if ((cntrlr_wren || cntrlr_rden) && cntrlr_rdy)
      begin
        issued_per[head[REQ_W +: AGENT_ID_W]]++;
      end

      exp_rv = '0;
      if (cntrlr_rd_valid)
      begin
        exp_rv[rd_pend[0][MEM_DATA_W +: AGENT_ID_W]] = 1'b1;
        assert (agent_rdata == rd_pend[0][MEM_DATA_W-1:0])
          else report_fail($sformatf("Error read_return: expected data %h, actual %h",
                                     rd_pend[0][MEM_DATA_W-1:0], agent_rdata));
        void'(rd_pend.pop_front());
      end
      assert (agent_rd_valid == exp_rv)
        else report_fail($sformatf("Error read_return: expected valid %b, actual %b",
                                   exp_rv, agent_rd_valid));

      // State changes of the coming rising edge
      if ((exp_wr || exp_rd) && cntrlr_rdy)
      begin
        void'(iss_q.pop_front());
        if (exp_rd)
        begin
          rdw = mem_model.exists(a) ? mem_model[a] : fill_word(a);
          rd_pend.push_back({head[REQ_W +: AGENT_ID_W], rdw});
        end
        else
        begin
          mem_model[a] = head[MEM_DATA_W-1:0];
        end
        issued++;
      end
      if ((sel >= 0) && arb_take)
      begin
        req = ingr_q[sel].pop_front();
        iss_q.push_back({AGENT_ID_W'(sel), req});
      end
      for (int i = 0; i < NUM_AGENTS; i++)
      begin
        if ((agent_wren[i] || agent_rden[i]) && !exp_wait[i])
        begin
          ingr_q[i].push_back({agent_wren[i], agent_rden[i], agent_addr[i], agent_wdata[i]});
        end
      end
    end
  end

  initial
  begin : main_seq
    repeat (2) @(posedge cntrlr_clk);
    cntrlr_rst_n <= 1'b1;
    run_en       <= 1'b1;
    @(negedge cntrlr_clk);
    assert ({cntrlr_wren, cntrlr_rden, agent_rd_valid, agent_wait} == '0)
      else report_fail($sformatf("Error reset: expected 0, actual %h",
                                 {cntrlr_wren, cntrlr_rden, agent_rd_valid, agent_wait}));
    while ((issued < NUM_REQ) || (rd_pend.size() != 0))
    begin
      @(posedge cntrlr_clk);
    end
    for (int i = 0; i < NUM_AGENTS; i++)
    begin
      assert (issued_per[i] == sent_per[i])
        else report_fail($sformatf("Error agent_order: expected %0d issued, actual %0d",
                                   sent_per[i], issued_per[i]));
    end
    assert (saw_full == '1)
      else report_fail("Some agent queue never filled during a controller stall");
    $display("Done: no errors");
    $finish;
  end

  initial
  begin : watchdog
    repeat (NUM_REQ * 40 + 200) @(posedge cntrlr_clk);
    report_fail("Timeout: the requests did not drain before the watchdog expired");
  end

endmodule

`default_nettype wire
